// ==== vlog.f ====
+incdir+src
src/cpu_pkg.sv
src/coproc0_eiu.sv
src/coproc0_regs.sv
src/coproc0.sv
verification/coproc0_sva.sv
verification/tb_coproc0.sv

// ==== run.sh ====
#!/bin/sh
# build the coproc0 testbench with Verilator and run it
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f vlog.f --top-module tb_coproc0 -o sim_coproc0 \
	&& ./obj_dir/sim_coproc0 | grep "Test OK" \
	|| { echo "simulation failed"; exit 1; }

// ==== verification/tb_coproc0.sv ====
/*
 * testbench for the coprocessor 0 top level.
 * clock, reset, directed error pulses and random stimulus.
 * cycle model of the stage registers, interrupt capture and register bank.
 * per-cycle checks of o_except, o_nullify and o_rdata, plus a watchdog.
 */

`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module tb_coproc0 import cpu_pkg::*; ();

	localparam int RST_CYCLES = 5;
	localparam int GAP_CYCLES = 8;
	// five setup writes plus twelve error and interrupt pulses.
	localparam int DIR_CYCLES = 10 + 12 * (GAP_CYCLES + 1);
	localparam int RAND_CYCLES = 4000;
	localparam int TOTAL_CYCLES = RST_CYCLES + DIR_CYCLES + RAND_CYCLES + 4;
	localparam int TIMEOUT_NS = TOTAL_CYCLES * 20 + 1000;

	logic clk;
	logic nrst;
	logic intr;
	pipe_ctl_t ctl;
	stage_err_t err;
	logic [`CPU_ADDR_WIDTH-1:0] pc_p3;
	cop0_wr_t wr;
	logic rfe;
	cop0_sel_t rd_sel;
	except_t o_except;
	nullify_t o_nullify;
	logic [`CPU_ADDR_WIDTH-1:0] o_rdata;

	integer seed = 32'h7d27_bd64;

	// model state, mirrors the state after the next rising edge.
	ex_code_t m_ex1, m_ex2, m_ex3;
	logic m_bub1, m_bub2, m_dly2, m_dly3;
	logic m_ilat, m_ival, m_itk3, m_itk4;
	logic m_valid;
	logic [`CPU_ADDR_WIDTH-1:0] m_haddr;
	logic m_ie, m_iep;
	logic [`CPU_IVTBASE_WIDTH-1:0] m_ivt;
	logic [`CPU_ADDR_WIDTH-1:0] m_epc;
	ex_code_t m_ccode;
	logic m_cbd;

	coproc0 u_dut (
		.clk(clk),
		.nrst(nrst),
		.i_intr(intr),
		.i_ctl(ctl),
		.i_err(err),
		.i_pc_p3(pc_p3),
		.i_wr(wr),
		.i_rfe(rfe),
		.i_rd_sel(rd_sel),
		.o_except(o_except),
		.o_nullify(o_nullify),
		.o_rdata(o_rdata)
	);

	always #10 clk = ~clk;

	// ##########################################################
	// helpers.
	// ##########################################################

	task automatic report_mismatch(input string name, input logic [37:0] got,
		input logic [37:0] exp);
		$display("Error: %s = %h, expected %h", name, got, exp);
		$display("Test FAILED");
		$fatal(1, "output mismatch");
	endtask

	// true with a chance of pct percent.
	task automatic roll_chance(input int pct, output logic hit);
		int r;
		r = $random(seed);
		r = r & 32'h7fff_ffff;
		hit = (r % 100) < pct;
	endtask

	task automatic model_reset;
		m_ex1 = EX_NONE;
		m_ex2 = EX_NONE;
		m_ex3 = EX_NONE;
		{m_bub1, m_bub2, m_dly2, m_dly3} = '0;
		{m_ilat, m_ival, m_itk3, m_itk4} = '0;
		m_valid = 1'b0;
		m_haddr = '0;
		{m_ie, m_iep} = '0;
		m_ivt = '0;
		m_epc = '0;
		m_ccode = EX_NONE;
		m_cbd = 1'b0;
	endtask

	// ##########################################################
	// reference model, one call per cycle at the falling edge.
	// ##########################################################

	task automatic model_step;
		logic stall, recent, itake, pend, push;
		logic s0, s1, s2, s3, any;
		ex_code_t code3;
		logic [37:0] exp_exc;
		logic [4:0] exp_null;
		logic [31:0] exp_rd;
		stall = ctl.fetch_stall | ctl.exec_stall | ctl.mem_stall;
		// no new interrupt within two slots of the last one.
		recent = m_itk3 | m_itk4;
		itake = m_ival & ~m_bub2 & ~recent;
		// pending cause per stage, carried or fresh.
		s0 = err.bus_p0 | err.addr_p0;
		s1 = (m_ex1 != EX_NONE) | err.decode_p1;
		s2 = (m_ex2 != EX_NONE) | err.overfl_p2 | err.addr_p2 | err.syscall_p2 |
			err.break_p2 | itake;
		s3 = (m_ex3 != EX_NONE) | err.bus_p3 | err.addr_p3;
		any = s0 | s1 | s2 | s3;
		code3 = err.bus_p3 ? EX_BUSERR : (err.addr_p3 ? EX_ADDRERR : m_ex3);
		exp_exc = {s3, m_dly3, m_valid, code3, m_haddr};
		exp_null = {any, any, s1 | s2 | s3, s2 | s3, s3};
		case (rd_sel)
			COP0_STATUS: exp_rd = {30'd0, m_iep, m_ie};
			COP0_IVTBASE: exp_rd = {m_ivt, 10'd0};
			COP0_EPC: exp_rd = m_epc;
			default: exp_rd = {m_cbd, 26'd0, m_ccode, 2'b00};
		endcase
		assert (o_except === exp_exc)
		else report_mismatch("o_except", o_except, exp_exc);
		assert (o_nullify === exp_null)
		else report_mismatch("o_nullify", 38'(o_nullify), 38'(exp_null));
		assert (o_rdata === exp_rd)
		else report_mismatch("o_rdata", 38'(o_rdata), 38'(exp_rd));
		// next state, older values are read before they are replaced.
		push = s3 & ~stall;
		pend = m_ilat | (intr & m_ie & ~m_ival);
		if (push)
		begin
			m_epc = m_dly3 ? pc_p3 - 32'd4 : pc_p3;
			m_ccode = code3;
			m_cbd = m_dly3;
		end
		if (stall)
			m_ilat = pend;
		else
		begin
			m_ilat = 1'b0;
			m_ival = pend & ~recent;
			m_bub2 = m_bub1;
			m_bub1 = any | ctl.jump_valid | m_valid;
			m_valid = s3;
			// vector offset is code times 0x40.
			if (s3)
				m_haddr = {m_ivt, 1'b0, code3, 6'd0};
			m_itk4 = m_itk3;
			m_itk3 = itake;
			m_dly3 = m_dly2;
			m_dly2 = ctl.jump_valid;
			if (itake)
				m_ex3 = EX_HWINTR;
			else if (err.overfl_p2)
				m_ex3 = EX_OVERFL;
			else if (err.addr_p2)
				m_ex3 = EX_ADDRERR;
			else if (err.syscall_p2)
				m_ex3 = EX_SYSCALL;
			else if (err.break_p2)
				m_ex3 = EX_BREAK;
			else
				m_ex3 = m_ex2;
			m_ex2 = err.decode_p1 ? EX_RESVDI : m_ex1;
			m_ex1 = err.bus_p0 ? EX_BUSERR : (err.addr_p0 ? EX_ADDRERR : EX_NONE);
		end
		// exception push beats a write, a write beats rfe.
		if (push)
		begin
			m_iep = m_ie;
			m_ie = 1'b0;
		end
		else if (wr.valid && wr.sel == COP0_STATUS)
		begin
			m_ie = wr.word[0];
			m_iep = wr.word[1];
		end
		else if (rfe)
			m_ie = m_iep;
		if (wr.valid && wr.sel == COP0_IVTBASE)
			m_ivt = wr.word[31:10];
	endtask

	always @(negedge clk)
	begin
		if (!nrst)
			model_reset;
		else
			model_step;
	end

	// ##########################################################
	// stimulus.
	// ##########################################################

	task automatic write_reg(input cop0_sel_t sel, input logic [31:0] word);
		@(posedge clk);
		wr <= {1'b1, sel, word};
		@(posedge clk);
		wr <= '0;
	endtask

	// one error flag for a cycle, then idle until it has drained.
	task automatic pulse_err(input int idx);
		@(posedge clk);
		err <= stage_err_t'(9'b1 << idx);
		@(posedge clk);
		err <= '0;
		repeat (GAP_CYCLES - 1) @(posedge clk);
	endtask

	task automatic pulse_intr;
		@(posedge clk);
		intr <= 1'b1;
		@(posedge clk);
		intr <= 1'b0;
		repeat (GAP_CYCLES - 1) @(posedge clk);
	endtask

	task automatic drive_random;
		pipe_ctl_t c;
		stage_err_t e;
		cop0_wr_t w;
		logic f, f_intr, f_rfe;
		logic [31:0] rv;
		int k;
		e = '0;
		for (k = 0; k < 9; k++)
		begin
			roll_chance(3, f);
			e[k] = f;
		end
		c = '0;
		roll_chance(10, f);
		if (f)
		begin
			k = ($random(seed) & 32'h7fff_ffff) % 3;
			c[k + 1] = 1'b1;
		end
		roll_chance(15, f);
		c.jump_valid = f;
		roll_chance(4, f);
		rv = $random(seed);
		w.valid = f;
		w.sel = cop0_sel_t'(rv[1:0]);
		w.word = $random(seed);
		roll_chance(5, f_intr);
		roll_chance(3, f_rfe);
		rv = $random(seed);
		@(posedge clk);
		ctl <= c;
		err <= e;
		wr <= w;
		intr <= f_intr;
		rfe <= f_rfe;
		pc_p3 <= rv & 32'hffff_fffc;
		rd_sel <= cop0_sel_t'(rv[31:30]);
	endtask

	initial
	begin
		clk = 1'b0;
		nrst = 1'b0;
		intr = 1'b0;
		ctl = '0;
		err = '0;
		pc_p3 = 32'h0000_1000;
		wr = '0;
		rfe = 1'b0;
		rd_sel = COP0_STATUS;
		repeat (RST_CYCLES) @(posedge clk);
		nrst <= 1'b1;
		// isolated errors, interrupts masked.
		write_reg(COP0_IVTBASE, 32'h1234_5400);
		write_reg(COP0_STATUS, 32'h0);
		for (int i = 0; i < 9; i++)
			pulse_err(i);
		// interrupt with ie set, then with ie popped to 0 by that exception.
		write_reg(COP0_STATUS, 32'h1);
		pulse_intr;
		pulse_intr;
		// ie set again and then cleared by a write.
		write_reg(COP0_STATUS, 32'h1);
		write_reg(COP0_STATUS, 32'h0);
		pulse_intr;
		repeat (RAND_CYCLES) drive_random;
		@(posedge clk);
		ctl <= '0;
		err <= '0;
		wr <= '0;
		intr <= 1'b0;
		rfe <= 1'b0;
		repeat (2) @(negedge clk);
		// last falling edge check is done by now.
		@(posedge clk);
		$display("Test OK");
		$finish;
	end

	// watchdog.
	initial
	begin
		#(TIMEOUT_NS);
		$display("Test FAILED");
		$fatal(1, "simulation did not finish within the time limit");
	end

endmodule

`default_nettype wire

// ==== verification/coproc0_sva.sv ====
/*
 * concurrent assertions on the coprocessor 0 outputs.
 * one redirect per exception, nullify ordering, handler base.
 * bound into the top level.
 */

`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module coproc0_sva import cpu_pkg::*; (
	input wire logic clk,
	input wire logic nrst,
	input wire pipe_ctl_t i_ctl,
	input wire except_t i_except,
	input wire nullify_t i_nullify,
	input wire logic [`CPU_IVTBASE_WIDTH-1:0] i_ivtbase
);

	logic core_stall;

	assign core_stall = i_ctl.fetch_stall | i_ctl.exec_stall | i_ctl.mem_stall;

	// ##########################################################
	// redirect and flush.
	// ##########################################################

	// an unstalled cycle without start ends the redirect.
	a_valid_single: assert property (@(posedge clk) disable iff (!nrst)
		(!core_stall && i_except.valid && !i_except.start) |=> !i_except.valid)
	else $error("redirect stayed valid without a new exception start");

	// a writeback flush means all younger stages go too.
	a_nullify_wb: assert property (@(posedge clk) disable iff (!nrst)
		i_nullify.wb |-> (i_nullify.fetch && i_nullify.decode &&
		i_nullify.execute && i_nullify.mem))
	else $error("writeback nullified while a younger stage was kept");

	// handler base is the table base of the capture cycle.
	a_haddr_base: assert property (@(posedge clk) disable iff (!nrst)
		$rose(i_except.valid) |->
		i_except.haddr[`CPU_ADDR_WIDTH-1:`CPU_ADDR_WIDTH-`CPU_IVTBASE_WIDTH] ==
		$past(i_ivtbase))
	else $error("handler address does not start at the vector table base");

endmodule

bind coproc0 coproc0_sva u_sva (
	.clk(clk),
	.nrst(nrst),
	.i_ctl(i_ctl),
	.i_except(o_except),
	.i_nullify(o_nullify),
	.i_ivtbase(ivtbase)
);

`default_nettype wire

// ==== src/coproc0.sv ====
/*
 * coprocessor 0 top level.
 * exceptions and interrupts unit plus register bank.
 */

`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module coproc0 import cpu_pkg::*; (
	input wire logic clk,
	input wire logic nrst,
	// external interrupt, already synchronous.
	input wire logic i_intr,
	// control unit flags.
	input wire pipe_ctl_t i_ctl,
	// stage error flags.
	input wire stage_err_t i_err,
	// memory stage pc.
	input wire logic [`CPU_ADDR_WIDTH-1:0] i_pc_p3,
	// software access.
	input wire cop0_wr_t i_wr,
	input wire logic i_rfe,
	input wire cop0_sel_t i_rd_sel,
	// redirect and flush.
	output except_t o_except,
	output nullify_t o_nullify,
	output logic [`CPU_ADDR_WIDTH-1:0] o_rdata
);

	// vector base and interrupt enable feed the unit.
	logic [`CPU_IVTBASE_WIDTH-1:0] ivtbase;
	logic ie;

	// exception bundle feeds the bank and the outputs.
	except_t except;

	// ##########################################################
	// exceptions and interrupts unit.
	// ##########################################################

	coproc0_eiu u_eiu (
		.clk(clk),
		.nrst(nrst),
		.i_intr(i_intr),
		.i_ctl(i_ctl),
		.i_err(i_err),
		.i_ivtbase(ivtbase),
		.i_ie(ie),
		.o_except(except),
		.o_nullify(o_nullify)
	);

	// ##########################################################
	// register bank.
	// ##########################################################

	coproc0_regs u_regs (
		.clk(clk),
		.nrst(nrst),
		.i_ctl(i_ctl),
		.i_except(except),
		.i_pc_p3(i_pc_p3),
		.i_wr(i_wr),
		.i_rfe(i_rfe),
		.i_rd_sel(i_rd_sel),
		.o_ivtbase(ivtbase),
		.o_ie(ie),
		.o_rdata(o_rdata)
	);

	assign o_except = except;

endmodule

`default_nettype wire

// ==== src/coproc0_regs.sv ====
/*
 * coprocessor 0 register bank.
 * STATUS interrupt enable stack, IVTBASE, EPC and CAUSE.
 * software writes, exception capture, rfe and read mux.
 */

`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module coproc0_regs import cpu_pkg::*; (
	input wire logic clk,
	input wire logic nrst,
	input wire pipe_ctl_t i_ctl,
	input wire except_t i_except,
	input wire logic [`CPU_ADDR_WIDTH-1:0] i_pc_p3,
	input wire cop0_wr_t i_wr,
	input wire logic i_rfe,
	input wire cop0_sel_t i_rd_sel,
	output logic [`CPU_IVTBASE_WIDTH-1:0] o_ivtbase,
	output logic o_ie,
	output logic [`CPU_ADDR_WIDTH-1:0] o_rdata
);

	logic core_stall;
	logic exc_push;
	logic wr_status, wr_ivtbase;
	logic ie, ie_prev;
	logic [`CPU_IVTBASE_WIDTH-1:0] ivtbase;
	logic [`CPU_ADDR_WIDTH-1:0] epc;
	ex_code_t cause_code;
	logic cause_bd;
	cop0_word_u status_word, ivt_word;

	assign core_stall = i_ctl.fetch_stall | i_ctl.exec_stall | i_ctl.mem_stall;

	// the memory stage only commits when the pipeline moves.
	assign exc_push = i_except.start & ~core_stall;

	// writes act regardless of stall.
	assign wr_status = i_wr.valid & (i_wr.sel == COP0_STATUS);
	assign wr_ivtbase = i_wr.valid & (i_wr.sel == COP0_IVTBASE);

	// ##########################################################
	// status and vector base.
	// ##########################################################

	// exception push beats a same-cycle write or rfe.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			ie <= 1'b0;
			ie_prev <= 1'b0;
		end
		else if (exc_push)
		begin
			ie_prev <= ie;
			ie <= 1'b0;
		end
		else if (wr_status)
		begin
			ie <= i_wr.word.status.ie;
			ie_prev <= i_wr.word.status.ie_prev;
		end
		else if (i_rfe)
			ie <= ie_prev;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			ivtbase <= '0;
		else if (wr_ivtbase)
			ivtbase <= i_wr.word.ivt.base;
	end

	// ##########################################################
	// exception capture.
	// ##########################################################

	// EPC and CAUSE are only loaded by hardware.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			epc <= '0;
			cause_code <= EX_NONE;
			cause_bd <= 1'b0;
		end
		else if (exc_push)
		begin
			// restart at the branch when the fault is in its delay slot.
			epc <= i_except.dly_slt ? i_pc_p3 - `CPU_ADDR_WIDTH'(4) : i_pc_p3;
			cause_code <= i_except.code;
			cause_bd <= i_except.dly_slt;
		end
	end

	// read views built through the union.
	always_comb
	begin
		status_word.status.rsvd = '0;
		status_word.status.ie_prev = ie_prev;
		status_word.status.ie = ie;
		ivt_word.ivt.base = ivtbase;
		ivt_word.ivt.zero = '0;
	end

	// CAUSE has BD at the top and the code at bits 4:2.
	always_comb
	begin
		case (i_rd_sel)
			COP0_STATUS: o_rdata = status_word;
			COP0_IVTBASE: o_rdata = ivt_word;
			COP0_EPC: o_rdata = epc;
			default: o_rdata = {cause_bd, {(`CPU_ADDR_WIDTH-6){1'b0}}, cause_code, 2'b00};
		endcase
	end

	assign o_ivtbase = ivtbase;
	assign o_ie = ie;

endmodule

`default_nettype wire

// ==== src/coproc0_eiu.sv ====
/*
 * coprocessor 0 exceptions and interrupts unit.
 * per-stage exception codes, bubble and delay slot tracking.
 * external interrupt capture with re-entry suppression.
 * cause priority, nullify flags and handler address.
 */

`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module coproc0_eiu import cpu_pkg::*; (
	input wire logic clk,
	input wire logic nrst,
	input wire logic i_intr,
	input wire pipe_ctl_t i_ctl,
	input wire stage_err_t i_err,
	input wire logic [`CPU_IVTBASE_WIDTH-1:0] i_ivtbase,
	input wire logic i_ie,
	output except_t o_except,
	output nullify_t o_nullify
);

	// handler offset of a cause.
	function automatic logic [9:0] vect_offs(input ex_code_t code);
		case (code)
			EX_BUSERR: vect_offs = `CPU_EXVECT_BUSERR;
			EX_OVERFL: vect_offs = `CPU_EXVECT_OVERFL;
			EX_ADDRERR: vect_offs = `CPU_EXVECT_ADDRERR;
			EX_RESVDI: vect_offs = `CPU_EXVECT_RESVDI;
			EX_BREAK: vect_offs = `CPU_EXVECT_BREAK;
			EX_SYSCALL: vect_offs = `CPU_EXVECT_SYSCALL;
			EX_HWINTR: vect_offs = `CPU_EXVECT_HWINTR;
			default: vect_offs = `CPU_EXVECT_RESET;
		endcase
	endfunction

	logic core_stall;
	ex_code_t ex_p1, ex_p2, ex_p3;
	logic bubble_p1, bubble_p2;
	logic dly_p2, dly_p3;
	logic intr_latch, intr_valid, intr_pend;
	logic intr_reg_p3, intr_reg_p4, intr_reg;
	logic intr_take;
	logic ex_state_p0, ex_state_p1, ex_state_p2, ex_state_p3;
	ex_code_t code_p3;
	logic except_valid;
	logic [`CPU_ADDR_WIDTH-1:0] except_haddr;

	// any stall holds the whole pipeline.
	assign core_stall = i_ctl.fetch_stall | i_ctl.exec_stall | i_ctl.mem_stall;

	// interrupt taken in one of the two previous slots.
	assign intr_reg = intr_reg_p3 | intr_reg_p4;

	// interrupt goes in at execute, only on a real instruction.
	assign intr_take = intr_valid & ~bubble_p2 & ~intr_reg;

	// ##########################################################
	// stage exception state.
	// ##########################################################

	assign ex_state_p0 = i_err.bus_p0 | i_err.addr_p0;
	assign ex_state_p1 = (ex_p1 != EX_NONE) | i_err.decode_p1;
	assign ex_state_p2 = (ex_p2 != EX_NONE) | i_err.overfl_p2 | i_err.addr_p2 |
		i_err.syscall_p2 | i_err.break_p2 | intr_take;
	assign ex_state_p3 = (ex_p3 != EX_NONE) | i_err.bus_p3 | i_err.addr_p3;

	// flush everything younger than the oldest faulting stage.
	assign o_nullify.fetch = ex_state_p0 | ex_state_p1 | ex_state_p2 | ex_state_p3;
	assign o_nullify.decode = ex_state_p0 | ex_state_p1 | ex_state_p2 | ex_state_p3;
	assign o_nullify.execute = ex_state_p1 | ex_state_p2 | ex_state_p3;
	assign o_nullify.mem = ex_state_p2 | ex_state_p3;
	assign o_nullify.wb = ex_state_p3;

	// fresh memory stage errors win over the carried code.
	always_comb
	begin
		if (i_err.bus_p3)
			code_p3 = EX_BUSERR;
		else if (i_err.addr_p3)
			code_p3 = EX_ADDRERR;
		else
			code_p3 = ex_p3;
	end

	// ##########################################################
	// decode and execute stages.
	// ##########################################################

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			ex_p1 <= EX_NONE;
			bubble_p1 <= 1'b0;
			ex_p2 <= EX_NONE;
			bubble_p2 <= 1'b0;
			dly_p2 <= 1'b0;
		end
		else if (!core_stall)
		begin
			// fetch errors, bus error first.
			if (i_err.bus_p0)
				ex_p1 <= EX_BUSERR;
			else if (i_err.addr_p0)
				ex_p1 <= EX_ADDRERR;
			else
				ex_p1 <= EX_NONE;
			// flushed or jumped-over fetch slots are bubbles.
			bubble_p1 <= o_nullify.fetch | i_ctl.jump_valid | except_valid;
			// a decode error overrides what came from fetch.
			ex_p2 <= i_err.decode_p1 ? EX_RESVDI : ex_p1;
			bubble_p2 <= bubble_p1;
			dly_p2 <= i_ctl.jump_valid;
		end
	end

	// ##########################################################
	// memory and writeback stages.
	// ##########################################################

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			ex_p3 <= EX_NONE;
			dly_p3 <= 1'b0;
			intr_reg_p3 <= 1'b0;
			intr_reg_p4 <= 1'b0;
			except_valid <= 1'b0;
			except_haddr <= '0;
		end
		else if (!core_stall)
		begin
			// interrupt first, then execute stage errors.
			if (intr_take)
				ex_p3 <= EX_HWINTR;
			else if (i_err.overfl_p2)
				ex_p3 <= EX_OVERFL;
			else if (i_err.addr_p2)
				ex_p3 <= EX_ADDRERR;
			else if (i_err.syscall_p2)
				ex_p3 <= EX_SYSCALL;
			else if (i_err.break_p2)
				ex_p3 <= EX_BREAK;
			else
				ex_p3 <= ex_p2;
			dly_p3 <= dly_p2;
			intr_reg_p3 <= intr_take;
			intr_reg_p4 <= intr_reg_p3;
			// redirect one cycle after the memory stage commits.
			except_valid <= ex_state_p3;
			if (ex_state_p3)
				except_haddr <= {i_ivtbase, vect_offs(code_p3)};
		end
	end

	// ##########################################################
	// external interrupt capture.
	// ##########################################################

	// sampling goes on while stalled.
	assign intr_pend = intr_latch | (i_intr & i_ie & ~intr_valid);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			intr_latch <= 1'b0;
			intr_valid <= 1'b0;
		end
		else if (core_stall)
			intr_latch <= intr_pend;
		else
		begin
			intr_latch <= 1'b0;
			intr_valid <= intr_pend & ~intr_reg;
		end
	end

	// exception bundle.
	assign o_except.start = ex_state_p3;
	assign o_except.dly_slt = dly_p3;
	assign o_except.valid = except_valid;
	assign o_except.code = code_p3;
	assign o_except.haddr = except_haddr;

endmodule

`default_nettype wire

// ==== src/cpu_pkg.sv ====
/*
 * shared cpu types.
 * exception codes, stage error flags, pipeline control and nullify flags.
 * exception bundle and coprocessor 0 register select.
 * coprocessor 0 write word with its status and vector base views.
 */

`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

	// exception cause codes, also the CAUSE register encoding.
	typedef enum logic [2:0] {
		EX_NONE,
		EX_BUSERR,
		EX_OVERFL,
		EX_ADDRERR,
		EX_RESVDI,
		EX_BREAK,
		EX_SYSCALL,
		EX_HWINTR
	} ex_code_t;

	// error flags, suffix gives the stage that raises them.
	typedef struct packed {
		logic bus_p0;
		logic addr_p0;
		logic decode_p1;
		logic overfl_p2;
		logic addr_p2;
		logic syscall_p2;
		logic break_p2;
		logic bus_p3;
		logic addr_p3;
	} stage_err_t;

	// stall and jump flags from the control unit.
	typedef struct packed {
		logic fetch_stall;
		logic exec_stall;
		logic mem_stall;
		logic jump_valid;
	} pipe_ctl_t;

	// result nullify per stage.
	typedef struct packed {
		logic fetch;
		logic decode;
		logic execute;
		logic mem;
		logic wb;
	} nullify_t;

	// exception bundle, start and code are combinational, valid and haddr registered.
	typedef struct packed {
		logic start;
		logic dly_slt;
		logic valid;
		ex_code_t code;
		logic [`CPU_ADDR_WIDTH-1:0] haddr;
	} except_t;

	// coprocessor 0 register select.
	typedef enum logic [1:0] {
		COP0_STATUS,
		COP0_IVTBASE,
		COP0_EPC,
		COP0_CAUSE
	} cop0_sel_t;

	// STATUS layout.
	typedef struct packed {
		logic [`CPU_ADDR_WIDTH-3:0] rsvd;
		logic ie_prev;
		logic ie;
	} cop0_status_t;

	// IVTBASE layout, low bits always zero.
	typedef struct packed {
		logic [`CPU_IVTBASE_WIDTH-1:0] base;
		logic [`CPU_ADDR_WIDTH-`CPU_IVTBASE_WIDTH-1:0] zero;
	} cop0_ivt_t;

	// one data word, decoded by the selected register.
	typedef union packed {
		cop0_status_t status;
		cop0_ivt_t ivt;
	} cop0_word_u;

	// single-cycle write strobe with target and data.
	typedef struct packed {
		logic valid;
		cop0_sel_t sel;
		cop0_word_u word;
	} cop0_wr_t;

endpackage

`default_nettype wire

// ==== src/cpu_defines.svh ====
/*
 * global cpu parameters.
 * address width and vector table base width.
 * exception handler offsets within the vector table.
 */

`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// ##########################################################
// widths.
// ##########################################################

// byte address width of the core.
`define CPU_ADDR_WIDTH		32

// vector table base, aligned to a 1 kbyte boundary.
`define CPU_IVTBASE_WIDTH	(`CPU_ADDR_WIDTH - 10)

// ##########################################################
// exception vector offsets.
// ##########################################################

// handler slots are 0x40 bytes apart.
`define CPU_EXVECT_RESET	10'h000
`define CPU_EXVECT_BUSERR	10'h040
`define CPU_EXVECT_OVERFL	10'h080
`define CPU_EXVECT_ADDRERR	10'h0c0
`define CPU_EXVECT_RESVDI	10'h100
`define CPU_EXVECT_BREAK	10'h140
`define CPU_EXVECT_SYSCALL	10'h180
`define CPU_EXVECT_HWINTR	10'h1c0

`endif
